// File: bench/mcpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcpu_defines.svh"

module mcpu_tb;

  import mcpu_pkg::*;

  localparam int ACC_W = 1 + $bits(mem_addr_t) + $bits(word_t);

  logic      clk;
  logic      reset;
  logic      load_en;
  mem_addr_t load_addr;
  word_t     load_data;
  logic      bus_rd;
  logic      bus_wr;
  mem_addr_t bus_addr;
  word_t     bus_wdata;

  // program image and instruction-set model state
  word_t image [`MCPU_MEM_DEPTH];
  word_t mmem [`MCPU_MEM_DEPTH];
  word_t mregs [`MCPU_NUM_REGS];
  word_t mpc;
  logic  mn;
  logic  mz;
  int    steps;
  int    asm_pc;
  int    end_addr;

  // predicted accesses as {wr, addr, wdata}
  logic [ACC_W-1:0] pending [$];
  logic      exp_wr;
  mem_addr_t exp_addr;
  word_t     exp_wdata;

  logic access_seen;
  logic done;
  int   consumed;
  int   acc_total;
  int   instr_total;
  int   cycles;
  int   limit;
  int   mismatches;
  int   failures;

  mcpu_top dut_i (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_load_en   (load_en),
    .i_load_addr (load_addr),
    .i_load_data (load_data),
    .o_bus_rd    (bus_rd),
    .o_bus_wr    (bus_wr),
    .o_bus_addr  (bus_addr),
    .o_bus_wdata (bus_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic put_word(input word_t w);
    image[asm_pc] = w;
    asm_pc++;
  endtask

  task automatic reg_form(input logic [3:0] op, input int rx, input int ry);
    put_word({5'b0, reg_idx_t'(ry), reg_idx_t'(rx), 1'b0, op});
  endtask

  task automatic imm_form(input logic [3:0] op, input int rx, input logic [7:0] imm);
    put_word({imm, reg_idx_t'(rx), 1'b1, op});
  endtask

  task automatic rel_form(input logic [3:0] op, input int off);
    put_word({11'(off), 1'b1, op});
  endtask

  task automatic load16(input int rx, input word_t v);
    imm_form(OP_MV, rx, v[7:0]);
    imm_form(OP_MVHI, rx, v[15:8]);
  endtask

  // st at the data pointer r6, then bump it
  task automatic store_out(input int rx);
    reg_form(OP_ST, rx, 6);
    imm_form(OP_ADD, 6, 8'd1);
  endtask

  task automatic build_program();
    word_t      a;
    word_t      b;
    logic [7:0] c;
    int         k;
    for (k = 0; k < `MCPU_MEM_DEPTH; k++) begin
      image[k] = {8'(~k), 8'(k)};
    end
    asm_pc = 0;
    imm_form(OP_MV, 6, 8'hC0);
    a = word_t'($urandom);
    b = word_t'($urandom);
    load16(1, a);
    load16(2, b);
    store_out(1);
    store_out(2);
    reg_form(OP_MV, 3, 1);
    store_out(3);
    reg_form(OP_ADD, 3, 2);
    store_out(3);
    imm_form(OP_ADD, 3, 8'($urandom));
    store_out(3);
    reg_form(OP_SUB, 3, 2);
    store_out(3);
    imm_form(OP_SUB, 3, 8'($urandom));
    store_out(3);
    // store, read back, store the copy
    load16(4, word_t'($urandom));
    reg_form(OP_ST, 4, 6);
    reg_form(OP_LD, 5, 6);
    imm_form(OP_ADD, 6, 8'd1);
    store_out(5);
    // first pass forces equal operands
    for (k = 0; k < 4; k++) begin
      c = 8'($urandom);
      a = (k == 0) ? {{8{c[7]}}, c} : word_t'($urandom);
      b = (k == 0) ? a : word_t'($urandom);
      load16(1, a);
      load16(2, b);
      reg_form(OP_CMP, 1, 2);
      rel_form(OP_JZ, 2);
      imm_form(OP_MV, 3, 8'h11);
      reg_form(OP_CMP, 1, 2);
      rel_form(OP_JN, 2);
      imm_form(OP_MV, 3, 8'h22);
      load16(5, word_t'(asm_pc + 5));
      imm_form(OP_CMP, 1, c);
      reg_form(OP_JZ, 5, 0);
      imm_form(OP_MV, 3, 8'h33);
      load16(5, word_t'(asm_pc + 5));
      imm_form(OP_CMP, 1, c);
      reg_form(OP_JN, 5, 0);
      imm_form(OP_MV, 3, 8'h44);
      store_out(3);
    end
    rel_form(OP_J, 2);
    imm_form(OP_MV, 3, 8'h55);
    load16(5, word_t'(asm_pc + 4));
    reg_form(OP_J, 5, 0);
    imm_form(OP_MV, 3, 8'h66);
    store_out(3);
    // subroutine stores r7 and returns through jr r7
    rel_form(OP_CALL, 4);
    store_out(7);
    rel_form(OP_J, 4);
    store_out(7);
    reg_form(OP_J, 7, 0);
    load16(5, word_t'(asm_pc + 4));
    reg_form(OP_CALL, 5, 0);
    rel_form(OP_J, 4);
    store_out(7);
    reg_form(OP_J, 7, 0);
    end_addr = asm_pc;
    rel_form(OP_J, 0);
  endtask

  task automatic reset_model();
    mmem = image;
    foreach (mregs[r]) begin
      mregs[r] = '0;
    end
    mpc = word_t'(`MCPU_RESET_PC);
    mn = 1'b0;
    mz = 1'b0;
    steps = 0;
    pending.delete();
  endtask

  task automatic push_access(input logic wr, input mem_addr_t a, input word_t d);
    pending.push_back({wr, a, d});
  endtask

  task automatic step_model();
    word_t      ins;
    word_t      imm8;
    word_t      bval;
    word_t      res;
    word_t      target;
    word_t      next_pc;
    logic [3:0] op;
    reg_idx_t   rx;
    reg_idx_t   ry;
    mem_addr_t  ea;
    ins = mmem[mem_addr_t'(mpc)];
    push_access(1'b0, mem_addr_t'(mpc), '0);
    op = ins[3:0];
    rx = ins[7:5];
    ry = ins[10:8];
    ea = mem_addr_t'(mregs[ry]);
    imm8 = {{8{ins[15]}}, ins[15:8]};
    bval = ins[4] ? imm8 : mregs[ry];
    // targets use the register value from before this instruction
    target = ins[4] ? mpc + {{5{ins[15]}}, ins[15:5]} : mregs[rx];
    next_pc = mpc + 1;
    case (op)
      OP_MV: mregs[rx] = ins[4] ? imm8 : mregs[ry];
      OP_ADD, OP_SUB, OP_CMP: begin
        res = (op == OP_ADD) ? mregs[rx] + bval : mregs[rx] - bval;
        mn = res[15];
        mz = (res == '0);
        if (op != OP_CMP) begin
          mregs[rx] = res;
        end
      end
      OP_LD: begin
        push_access(1'b0, ea, '0);
        mregs[rx] = mmem[ea];
      end
      OP_ST: begin
        push_access(1'b1, ea, mregs[rx]);
        mmem[ea] = mregs[rx];
      end
      OP_MVHI: mregs[rx] = {ins[15:8], mregs[rx][7:0]};
      OP_J: next_pc = target;
      OP_JZ: next_pc = mz ? target : next_pc;
      OP_JN: next_pc = mn ? target : next_pc;
      OP_CALL: begin
        mregs[7] = mpc + 1;
        next_pc = target;
      end
      default: next_pc = mregs[rx];
    endcase
    mpc = next_pc;
    steps++;
  endtask

  task automatic next_expect();
    if (pending.size() == 0) begin
      step_model();
    end
    {exp_wr, exp_addr, exp_wdata} = pending.pop_front();
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  always @(negedge clk) begin
    access_seen <= !reset && (bus_rd || bus_wr);
  end

  // retire the access of the cycle that just ended
  always @(posedge clk) begin
    if (access_seen) begin
      consumed = consumed + 1;
      if (consumed == acc_total) begin
        done = 1'b1;
      end
      next_expect();
    end
  end

  a_rd_wr_excl: assert property (@(negedge clk) !(bus_rd && bus_wr))
    else begin
      failures++;
      $display("%0t: read and write strobes are high together", $time);
    end

  a_no_write_in_reset: assert property (@(negedge clk) reset |-> !bus_wr)
    else begin
      failures++;
      $display("%0t: memory write seen while reset is high", $time);
    end

  a_access_kind: assert property (
    @(negedge clk) disable iff (reset)
    (bus_rd || bus_wr) |-> (bus_wr == exp_wr)
  ) else begin
    mismatches++;
    $display("Mismatch at %0t: expected %s, got %s", $time,
             exp_wr ? "write" : "read", bus_wr ? "write" : "read");
  end

  a_access_addr: assert property (
    @(negedge clk) disable iff (reset)
    (bus_rd || bus_wr) |-> (bus_addr == exp_addr)
  ) else begin
    mismatches++;
    $display("Mismatch at %0t: address expected %h, got %h", $time, exp_addr, bus_addr);
  end

  a_store_data: assert property (
    @(negedge clk) disable iff (reset)
    bus_wr |-> (bus_wdata == exp_wdata)
  ) else begin
    mismatches++;
    $display("Mismatch at %0t: store data expected %h, got %h", $time, exp_wdata, bus_wdata);
  end

  initial begin
    int i;
    void'($urandom(39));
    reset = 1'b1;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    access_seen = 1'b0;
    done = 1'b0;
    consumed = 0;
    cycles = 0;
    mismatches = 0;
    failures = 0;
    build_program();
    // dry run up to the final self loop
    reset_model();
    while (mpc != word_t'(end_addr) && steps < 1000) begin
      step_model();
    end
    instr_total = steps;
    acc_total = pending.size() + 1;
    reset_model();
    next_expect();
    for (i = 0; i < `MCPU_MEM_DEPTH; i++) begin
      @(posedge clk);
      #1;
      load_en = 1'b1;
      load_addr = mem_addr_t'(i);
      load_data = image[i];
    end
    @(posedge clk);
    #1;
    load_en = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    limit = cycles + 4 * instr_total * 4;
    while (!done && cycles < limit) begin
      @(negedge clk);
    end
    if (!done) begin
      failures++;
      $display("timeout: program did not reach its final loop within %0d cycles", limit);
    end
    $display("mismatches: %0d, other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
  input  wire                 i_clk,
  input  wire                 i_reset,

  output logic                o_mem_rd,
  output logic                o_mem_wr,
  output logic                o_mem_addr_sel,

  output mcpu_pkg::pc_sel_t   o_pc_sel,
  output logic                o_pc_ld,

  input  wire mcpu_pkg::ir_op_t i_ir,
  output logic                o_ir_ld,

  output mcpu_pkg::rf_sel_t   o_rf_sel,
  output logic                o_rf_write,
  output logic                o_rf_addr_w_sel,

  input  wire                 i_alu_n,
  input  wire                 i_alu_z,
  output logic                o_alu_n_ld,
  output logic                o_alu_z_ld,
  output logic                o_alu_b_sel,
  output logic                o_alu_op
);

  import mcpu_pkg::*;

  typedef enum logic [1:0] {
    FETCH,
    LD_IR,
    EXECUTE,
    MEM_LD
  } state_t;

  state_t  state;
  state_t  state_next;
  logic    imm_op;
  pc_sel_t jump_sel;

  assign imm_op = i_ir[4];

  // immediate form jumps relative to the pc, register form to rx
  assign jump_sel = imm_op ? PC_SEL_REL : PC_SEL_RX;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state <= FETCH;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next      = state;
    o_mem_rd        = 1'b0;
    o_mem_wr        = 1'b0;
    o_mem_addr_sel  = 1'b0;
    o_pc_sel        = PC_SEL_RX;
    o_pc_ld         = 1'b0;
    o_ir_ld         = 1'b0;
    o_rf_sel        = RF_SEL_IMM;
    o_rf_write      = 1'b0;
    o_rf_addr_w_sel = 1'b0;
    o_alu_n_ld      = 1'b0;
    o_alu_z_ld      = 1'b0;
    o_alu_b_sel     = 1'b0;
    o_alu_op        = 1'b0;

    case (state)
      FETCH: begin
        state_next = LD_IR;
        o_mem_rd   = 1'b1;
      end

      LD_IR: begin
        state_next = EXECUTE;
        o_ir_ld    = 1'b1;
      end

      EXECUTE: begin
        // every instruction updates the pc here
        state_next = FETCH;
        o_pc_ld    = 1'b1;
        o_pc_sel   = PC_SEL_INC;

        case (i_ir[3:0])
          OP_MV: begin
            o_rf_write = 1'b1;
            o_rf_sel   = imm_op ? RF_SEL_IMM : RF_SEL_RY;
          end
          OP_ADD, OP_SUB: begin
            o_rf_sel    = RF_SEL_ALU;
            o_rf_write  = 1'b1;
            o_alu_n_ld  = 1'b1;
            o_alu_z_ld  = 1'b1;
            o_alu_op    = (i_ir[3:0] == OP_SUB);
            o_alu_b_sel = !imm_op;
          end
          OP_CMP: begin
            // subtract for flags only
            o_alu_n_ld  = 1'b1;
            o_alu_z_ld  = 1'b1;
            o_alu_op    = 1'b1;
            o_alu_b_sel = !imm_op;
          end
          OP_LD: begin
            state_next     = MEM_LD;
            o_mem_rd       = 1'b1;
            o_mem_addr_sel = 1'b1;
          end
          OP_ST: begin
            o_mem_wr       = 1'b1;
            o_mem_addr_sel = 1'b1;
          end
          OP_MVHI: begin
            o_rf_sel   = RF_SEL_HI;
            o_rf_write = 1'b1;
          end
          OP_J: begin
            o_pc_sel = jump_sel;
          end
          OP_JZ: begin
            if (i_alu_z) begin
              o_pc_sel = jump_sel;
            end
          end
          OP_JN: begin
            if (i_alu_n) begin
              o_pc_sel = jump_sel;
            end
          end
          OP_CALL: begin
            o_pc_sel        = jump_sel;
            o_rf_sel        = RF_SEL_RET;
            o_rf_write      = 1'b1;
            o_rf_addr_w_sel = 1'b1;
          end
          default: begin
            // unknown opcodes fall through to a jump via rx
            o_pc_sel = PC_SEL_RX;
          end
        endcase
      end

      MEM_LD: begin
        state_next = FETCH;
        o_rf_sel   = RF_SEL_MEM;
        o_rf_write = 1'b1;
      end
    endcase
  end

  // memory has a single port shared by reads and writes
  a_mem_rd_wr_excl: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !(o_mem_rd && o_mem_wr)
  );

  // no instruction longer than ld
  a_fetch_recurs: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (state == FETCH) |-> ##[1:4] (state == FETCH)
  );

endmodule

`default_nettype wire

// File: design/mcpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcpu_defines.svh"

module mcpu_datapath (
  input  wire                     i_clk,
  input  wire                     i_reset,

  input  wire                     i_mem_addr_sel,
  input  wire mcpu_pkg::pc_sel_t  i_pc_sel,
  input  wire                     i_pc_ld,
  input  wire                     i_ir_ld,
  input  wire mcpu_pkg::rf_sel_t  i_rf_sel,
  input  wire                     i_rf_addr_w_sel,
  input  wire                     i_alu_n_ld,
  input  wire                     i_alu_z_ld,
  input  wire                     i_alu_b_sel,
  input  wire                     i_alu_op,

  input  wire mcpu_pkg::word_t    i_mem_rdata,
  input  wire mcpu_pkg::word_t    i_rf_rx_data,
  input  wire mcpu_pkg::word_t    i_rf_ry_data,

  output mcpu_pkg::ir_op_t        o_ir,
  output logic                    o_alu_n,
  output logic                    o_alu_z,
  output mcpu_pkg::mem_addr_t     o_mem_addr,
  output mcpu_pkg::word_t         o_mem_wdata,
  output mcpu_pkg::reg_idx_t      o_rf_rx_idx,
  output mcpu_pkg::reg_idx_t      o_rf_ry_idx,
  output mcpu_pkg::reg_idx_t      o_rf_w_idx,
  output mcpu_pkg::word_t         o_rf_wdata
);

  import mcpu_pkg::*;

  word_t pc;
  word_t pc_inc;
  word_t pc_next;
  word_t ir;
  word_t imm8_sext;
  word_t imm11_sext;
  word_t alu_b;
  word_t alu_result;

  assign imm8_sext  = {{8{ir[15]}}, ir[15:8]};
  assign imm11_sext = {{5{ir[15]}}, ir[15:5]};

  // pc still holds the address of the executing instruction
  assign pc_inc = pc + word_t'(1);

  always_comb begin
    case (i_pc_sel)
      PC_SEL_RX:  pc_next = i_rf_rx_data;
      PC_SEL_INC: pc_next = pc_inc;
      PC_SEL_REL: pc_next = pc + imm11_sext;
      default:    pc_next = pc_inc;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      pc <= word_t'(`MCPU_RESET_PC);
      ir <= '0;
    end else begin
      if (i_pc_ld) begin
        pc <= pc_next;
      end
      if (i_ir_ld) begin
        ir <= i_mem_rdata;
      end
    end
  end

  // b is ry for register forms, imm8 otherwise
  assign alu_b      = i_alu_b_sel ? i_rf_ry_data : imm8_sext;
  assign alu_result = i_alu_op ? (i_rf_rx_data - alu_b) : (i_rf_rx_data + alu_b);

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_alu_n <= 1'b0;
      o_alu_z <= 1'b0;
    end else begin
      if (i_alu_n_ld) begin
        o_alu_n <= alu_result[`MCPU_WORD_W-1];
      end
      if (i_alu_z_ld) begin
        o_alu_z <= (alu_result == '0);
      end
    end
  end

  always_comb begin
    case (i_rf_sel)
      RF_SEL_IMM: o_rf_wdata = imm8_sext;
      RF_SEL_HI:  o_rf_wdata = {ir[15:8], i_rf_rx_data[7:0]};
      RF_SEL_ALU: o_rf_wdata = alu_result;
      RF_SEL_RET: o_rf_wdata = pc_inc;
      RF_SEL_MEM: o_rf_wdata = i_mem_rdata;
      RF_SEL_RY:  o_rf_wdata = i_rf_ry_data;
      default:    o_rf_wdata = '0;
    endcase
  end

  assign o_ir        = ir[4:0];
  assign o_rf_rx_idx = ir[7:5];
  assign o_rf_ry_idx = ir[10:8];
  assign o_rf_w_idx  = i_rf_addr_w_sel ? LINK_REG : ir[7:5];

  // word address is the low byte of pc or ry
  assign o_mem_addr  = i_mem_addr_sel ? mem_addr_t'(i_rf_ry_data) : mem_addr_t'(pc);
  assign o_mem_wdata = i_rf_rx_data;

endmodule

`default_nettype wire

// File: design/mcpu_defines.svh
`ifndef MCPU_DEFINES_SVH
`define MCPU_DEFINES_SVH

// data and instruction width
`define MCPU_WORD_W 16

// unified program/data memory, in words
`define MCPU_MEM_DEPTH 256

// general purpose registers, the last one is the link register
`define MCPU_NUM_REGS 8

// first fetch address
`define MCPU_RESET_PC 0

`endif

// File: design/mcpu_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcpu_defines.svh"

module mcpu_memory (
  input  wire                      i_clk,

  // cpu port
  input  wire                      i_rd,
  input  wire                      i_wr,
  input  wire mcpu_pkg::mem_addr_t i_addr,
  input  wire mcpu_pkg::word_t     i_wdata,

  // load port, used while the core sits in reset
  input  wire                      i_load_en,
  input  wire mcpu_pkg::mem_addr_t i_load_addr,
  input  wire mcpu_pkg::word_t     i_load_data,

  output mcpu_pkg::word_t          o_rdata
);

  import mcpu_pkg::*;

  word_t mem [`MCPU_MEM_DEPTH];

  always_ff @(posedge i_clk) begin
    // load port wins over a cpu store
    if (i_load_en) begin
      mem[i_load_addr] <= i_load_data;
    end else if (i_wr) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // read data valid the cycle after i_rd
  always_ff @(posedge i_clk) begin
    if (i_rd) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

`default_nettype wire

// File: design/mcpu_pkg.sv
`default_nettype none

`include "mcpu_defines.svh"

package mcpu_pkg;

  typedef logic [`MCPU_WORD_W-1:0] word_t;
  typedef logic [$clog2(`MCPU_MEM_DEPTH)-1:0] mem_addr_t;
  typedef logic [$clog2(`MCPU_NUM_REGS)-1:0] reg_idx_t;

  // bit 4 marks the immediate form
  typedef logic [4:0] ir_op_t;
  typedef logic [1:0] pc_sel_t;
  typedef logic [2:0] rf_sel_t;

  localparam pc_sel_t PC_SEL_RX  = 2'd0;
  localparam pc_sel_t PC_SEL_INC = 2'd1;
  localparam pc_sel_t PC_SEL_REL = 2'd2;

  localparam rf_sel_t RF_SEL_IMM = 3'd0;
  localparam rf_sel_t RF_SEL_HI  = 3'd1;
  localparam rf_sel_t RF_SEL_ALU = 3'd2;
  localparam rf_sel_t RF_SEL_RET = 3'd3;
  localparam rf_sel_t RF_SEL_MEM = 3'd4;
  localparam rf_sel_t RF_SEL_RY  = 3'd5;

  localparam logic [3:0] OP_MV   = 4'h0;
  localparam logic [3:0] OP_ADD  = 4'h1;
  localparam logic [3:0] OP_SUB  = 4'h2;
  localparam logic [3:0] OP_CMP  = 4'h3;
  localparam logic [3:0] OP_LD   = 4'h4;
  localparam logic [3:0] OP_ST   = 4'h5;
  localparam logic [3:0] OP_MVHI = 4'h6;
  localparam logic [3:0] OP_J    = 4'h8;
  localparam logic [3:0] OP_JZ   = 4'h9;
  localparam logic [3:0] OP_JN   = 4'hA;
  localparam logic [3:0] OP_CALL = 4'hC;

  // callr and call leave the return address here
  localparam reg_idx_t LINK_REG = reg_idx_t'(`MCPU_NUM_REGS - 1);

endpackage

`default_nettype wire

// File: design/mcpu_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcpu_defines.svh"

module mcpu_regfile (
  input  wire                     i_clk,
  input  wire                     i_reset,
  input  wire mcpu_pkg::reg_idx_t i_rx_idx,
  input  wire mcpu_pkg::reg_idx_t i_ry_idx,
  input  wire mcpu_pkg::reg_idx_t i_w_idx,
  input  wire                     i_write,
  input  wire mcpu_pkg::word_t    i_wdata,
  output mcpu_pkg::word_t         o_rx_data,
  output mcpu_pkg::word_t         o_ry_data
);

  import mcpu_pkg::*;

  word_t regs [`MCPU_NUM_REGS];

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      for (int i = 0; i < `MCPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_write) begin
      regs[i_w_idx] <= i_wdata;
    end
  end

  // read ports are combinational
  assign o_rx_data = regs[i_rx_idx];
  assign o_ry_data = regs[i_ry_idx];

  // write index comes from the ir or the control link select
  a_w_idx_known: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_write |-> !$isunknown(i_w_idx)
  );

endmodule

`default_nettype wire

// File: design/mcpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mcpu_top (
  input  wire                      i_clk,
  input  wire                      i_reset,

  input  wire                      i_load_en,
  input  wire mcpu_pkg::mem_addr_t i_load_addr,
  input  wire mcpu_pkg::word_t     i_load_data,

  // every cpu memory access, as it happens
  output logic                     o_bus_rd,
  output logic                     o_bus_wr,
  output mcpu_pkg::mem_addr_t      o_bus_addr,
  output mcpu_pkg::word_t          o_bus_wdata
);

  import mcpu_pkg::*;

  logic     mem_addr_sel;
  pc_sel_t  pc_sel;
  logic     pc_ld;
  logic     ir_ld;
  rf_sel_t  rf_sel;
  logic     rf_write;
  logic     rf_addr_w_sel;
  logic     alu_n_ld;
  logic     alu_z_ld;
  logic     alu_b_sel;
  logic     alu_op;
  ir_op_t   ir_op;
  logic     alu_n;
  logic     alu_z;
  word_t    mem_rdata;
  word_t    rf_rx_data;
  word_t    rf_ry_data;
  reg_idx_t rf_rx_idx;
  reg_idx_t rf_ry_idx;
  reg_idx_t rf_w_idx;
  word_t    rf_wdata;

  cpu_control control_i (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .o_mem_rd        (o_bus_rd),
    .o_mem_wr        (o_bus_wr),
    .o_mem_addr_sel  (mem_addr_sel),
    .o_pc_sel        (pc_sel),
    .o_pc_ld         (pc_ld),
    .i_ir            (ir_op),
    .o_ir_ld         (ir_ld),
    .o_rf_sel        (rf_sel),
    .o_rf_write      (rf_write),
    .o_rf_addr_w_sel (rf_addr_w_sel),
    .i_alu_n         (alu_n),
    .i_alu_z         (alu_z),
    .o_alu_n_ld      (alu_n_ld),
    .o_alu_z_ld      (alu_z_ld),
    .o_alu_b_sel     (alu_b_sel),
    .o_alu_op        (alu_op)
  );

  mcpu_datapath datapath_i (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_mem_addr_sel  (mem_addr_sel),
    .i_pc_sel        (pc_sel),
    .i_pc_ld         (pc_ld),
    .i_ir_ld         (ir_ld),
    .i_rf_sel        (rf_sel),
    .i_rf_addr_w_sel (rf_addr_w_sel),
    .i_alu_n_ld      (alu_n_ld),
    .i_alu_z_ld      (alu_z_ld),
    .i_alu_b_sel     (alu_b_sel),
    .i_alu_op        (alu_op),
    .i_mem_rdata     (mem_rdata),
    .i_rf_rx_data    (rf_rx_data),
    .i_rf_ry_data    (rf_ry_data),
    .o_ir            (ir_op),
    .o_alu_n         (alu_n),
    .o_alu_z         (alu_z),
    .o_mem_addr      (o_bus_addr),
    .o_mem_wdata     (o_bus_wdata),
    .o_rf_rx_idx     (rf_rx_idx),
    .o_rf_ry_idx     (rf_ry_idx),
    .o_rf_w_idx      (rf_w_idx),
    .o_rf_wdata      (rf_wdata)
  );

  mcpu_regfile regfile_i (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_rx_idx  (rf_rx_idx),
    .i_ry_idx  (rf_ry_idx),
    .i_w_idx   (rf_w_idx),
    .i_write   (rf_write),
    .i_wdata   (rf_wdata),
    .o_rx_data (rf_rx_data),
    .o_ry_data (rf_ry_data)
  );

  // memory sees the same nets as the bus monitor
  mcpu_memory memory_i (
    .i_clk       (i_clk),
    .i_rd        (o_bus_rd),
    .i_wr        (o_bus_wr),
    .i_addr      (o_bus_addr),
    .i_wdata     (o_bus_wdata),
    .i_load_en   (i_load_en),
    .i_load_addr (i_load_addr),
    .i_load_data (i_load_data),
    .o_rdata     (mem_rdata)
  );

endmodule

`default_nettype wire

// File: mcpu.f
+incdir+design
design/mcpu_pkg.sv
design/cpu_control.sv
design/mcpu_datapath.sv
design/mcpu_regfile.sv
design/mcpu_memory.sv
design/mcpu_top.sv
bench/mcpu_tb.sv
